/* hw/issue_pkg.sv */
package issue_pkg;

    // datapath widths
    localparam int XLEN        = 64;   // integer operand width
    localparam int ILEN        = 32;   // instruction width
    localparam int REG_IDX_LEN = 5;    // architectural register index
    localparam int I_IMM       = 12;   // raw immediate width (I, S, and B without bit 0)
    localparam int EU_N        = 4;    // reservation stations fed by the issue stage

    typedef logic [XLEN-1:0]        xlen_t;
    typedef logic [ILEN-1:0]        instr_t;
    typedef logic [REG_IDX_LEN-1:0] reg_idx_t;
    typedef logic [I_IMM-1:0]       imm_t;
    typedef logic [7:0]             eu_ctl_t;       // funct3 plus the funct7 alt bit
    typedef logic [3:0]             except_code_t;
    typedef logic [2:0]             eu_sel_t;
    typedef logic [6:0]             opcode_t;
    typedef logic                   imm_format_t;

    // target units, each code is also the bit index in ex_valid/ex_ready
    localparam eu_sel_t EU_LOAD_BUFFER  = 3'd0;
    localparam eu_sel_t EU_STORE_BUFFER = 3'd1;
    localparam eu_sel_t EU_BRANCH_UNIT  = 3'd2;
    localparam eu_sel_t EU_INT_ALU      = 3'd3;
    localparam eu_sel_t EU_NONE         = 3'd4;   // straight to the ROB

    // how the ALU reads the immediate
    localparam imm_format_t IMM_SEXT  = 1'b0;
    localparam imm_format_t IMM_SHAMT = 1'b1;   // 6-bit shift amount, zero extended

    // mcause values
    localparam except_code_t E_ILLEGAL_INSTR = 4'd2;
    localparam except_code_t E_BREAKPOINT    = 4'd3;
    localparam except_code_t E_ENV_CALL_M    = 4'd11;

    // major opcodes of the supported RV64I subset
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

endpackage

/* hw/issue_decoder.sv */
`timescale 1ns/100ps

module issue_decoder import issue_pkg::*; (
    input  instr_t       instr_i,
    output reg_idx_t     rs1_idx_o,
    output reg_idx_t     rs2_idx_o,
    output reg_idx_t     rd_idx_o,
    output eu_sel_t      eu_o,             // target reservation station
    output eu_ctl_t      eu_ctl_o,
    output logic         rs1_req_o,
    output logic         rs2_req_o,
    output logic         imm_req_o,        // ALU takes the immediate as rs2
    output imm_format_t  imm_format_o,
    output logic         regstat_upd_o,    // instr writes rd
    output logic         res_ready_o,      // ROB entry ready to commit at once
    output logic         stall_possible_o,
    output logic         except_raised_o,
    output except_code_t except_code_o
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic       sys_fields_zero;   // rd, funct3 and rs1 all zero

    // fixed RISC-V field positions
    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign rd_idx_o  = instr_i[11:7];
    assign rs1_idx_o = instr_i[19:15];
    assign rs2_idx_o = instr_i[24:20];

    assign sys_fields_zero = (instr_i[19:7] == '0);

    always_comb begin
        // defaults match an illegal instruction
        eu_o             = EU_NONE;
        eu_ctl_o         = '0;
        rs1_req_o        = 1'b0;
        rs2_req_o        = 1'b0;
        imm_req_o        = 1'b0;
        imm_format_o     = IMM_SEXT;
        regstat_upd_o    = 1'b0;
        res_ready_o      = 1'b0;
        stall_possible_o = 1'b1;
        except_raised_o  = 1'b1;
        except_code_o    = E_ILLEGAL_INSTR;

        eu_ctl_o[2:0] = funct3;   // units pick the operation from funct3

        case (opcode)
            OPC_LOAD: begin
                eu_o             = EU_LOAD_BUFFER;
                rs1_req_o        = 1'b1;   // base address
                regstat_upd_o    = 1'b1;
                stall_possible_o = 1'b0;
                except_raised_o  = 1'b0;
            end
            OPC_STORE, OPC_BRANCH: begin
                eu_o             = (opcode == OPC_STORE) ? EU_STORE_BUFFER : EU_BRANCH_UNIT;
                rs1_req_o        = 1'b1;
                rs2_req_o        = 1'b1;   // store data or compare operand
                stall_possible_o = 1'b0;
                except_raised_o  = 1'b0;
            end
            OPC_OP_IMM: begin
                eu_o             = EU_INT_ALU;
                rs1_req_o        = 1'b1;
                imm_req_o        = 1'b1;
                regstat_upd_o    = 1'b1;
                stall_possible_o = 1'b0;
                except_raised_o  = 1'b0;
                if (funct3 == 3'd1 || funct3 == 3'd5) begin
                    imm_format_o = IMM_SHAMT;   // slli, srli, srai
                end
                if (funct3 == 3'd5) begin
                    eu_ctl_o[3] = instr_i[30];  // srai vs srli
                end
            end
            OPC_OP: begin
                eu_o             = EU_INT_ALU;
                rs1_req_o        = 1'b1;
                rs2_req_o        = 1'b1;
                regstat_upd_o    = 1'b1;
                stall_possible_o = 1'b0;
                except_raised_o  = 1'b0;
                eu_ctl_o[3]      = instr_i[30]; // sub / sra
            end
            OPC_MISC_MEM: begin
                res_ready_o     = 1'b1;          // fence commits in order anyway
                except_raised_o = 1'b0;
            end
            OPC_SYSTEM: begin
                if (sys_fields_zero && instr_i[31:20] == 12'h000) begin
                    res_ready_o   = 1'b1;        // ecall
                    except_code_o = E_ENV_CALL_M;
                end else if (sys_fields_zero && instr_i[31:20] == 12'h001) begin
                    res_ready_o   = 1'b1;        // ebreak
                    except_code_o = E_BREAKPOINT;
                end
            end
            default: ;   // keep the illegal defaults
        endcase
    end

endmodule

/* hw/operand_source_sel.sv */
`timescale 1ns/100ps

module operand_source_sel import issue_pkg::*; #(
    parameter int ROB_IDX_LEN = 4
) (
    input  logic                   req_i,               // operand used by the instr
    input  logic                   busy_i,              // producer still in flight
    input  logic [ROB_IDX_LEN-1:0] rob_idx_i,           // producer ROB entry
    input  xlen_t                  rf_value_i,
    input  logic                   rob_ready_i,         // result already in the ROB
    input  xlen_t                  rob_value_i,
    input  logic                   cdb_valid_i,
    input  logic                   cdb_except_raised_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    input  xlen_t                  cdb_value_i,
    output logic                   ready_o,
    output xlen_t                  value_o
);

    logic cdb_hit;   // producer broadcasting right now

    assign cdb_hit = cdb_valid_i && !cdb_except_raised_i && (cdb_rob_idx_i == rob_idx_i);

    // priority RF, then ROB, then CDB
    always_comb begin
        ready_o = 1'b0;
        value_o = '0;
        if (req_i) begin
            if (!busy_i) begin
                ready_o = 1'b1;
                value_o = rf_value_i;
            end else if (rob_ready_i) begin
                ready_o = 1'b1;
                value_o = rob_value_i;
            end else if (cdb_hit) begin
                ready_o = 1'b1;
                value_o = cdb_value_i;
            end
            // else the station snoops the CDB later
        end
    end

endmodule

/* hw/imm_operand_mux.sv */
`timescale 1ns/100ps

module imm_operand_mux import issue_pkg::*; (
    input  instr_t      instr_i,
    input  eu_sel_t     eu_i,
    input  logic        imm_req_i,
    input  imm_format_t imm_format_i,
    input  xlen_t       rs1_value_i,
    input  xlen_t       rs2_value_i,
    output xlen_t       ex_rs1_value_o,
    output xlen_t       ex_rs2_value_o,
    output imm_t        ex_imm_value_o
);

    imm_t  imm_i;
    imm_t  imm_s;
    imm_t  imm_b;      // bits 12..1, bit 0 is always zero
    xlen_t alu_imm;    // immediate as the ALU second operand

    assign imm_i = instr_i[31:20];
    assign imm_s = {instr_i[31:25], instr_i[11:7]};
    assign imm_b = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};

    assign alu_imm = (imm_format_i == IMM_SHAMT) ?
                     {{(XLEN-6){1'b0}}, imm_i[5:0]} :
                     {{(XLEN-I_IMM){imm_i[I_IMM-1]}}, imm_i};

    always_comb begin
        ex_rs1_value_o = '0;
        ex_rs2_value_o = '0;
        ex_imm_value_o = '0;
        case (eu_i)
            EU_LOAD_BUFFER: begin
                ex_rs1_value_o = rs1_value_i;   // base
                ex_imm_value_o = imm_i;         // offset
            end
            EU_STORE_BUFFER: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;   // store data
                ex_imm_value_o = imm_s;
            end
            EU_BRANCH_UNIT: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = rs2_value_i;
                ex_imm_value_o = imm_b;         // pc relative target offset
            end
            EU_INT_ALU: begin
                ex_rs1_value_o = rs1_value_i;
                ex_rs2_value_o = imm_req_i ? alu_imm : rs2_value_i;
            end
            default: ;   // EU_NONE carries no operands
        endcase
    end

endmodule

/* hw/issue_control.sv */
`timescale 1ns/100ps

module issue_control import issue_pkg::*; (
    input  logic            iq_valid_i,
    input  logic            rob_ready_i,
    input  logic            regstat_ready_i,
    input  logic [EU_N-1:0] ex_ready_i,
    input  eu_sel_t         eu_i,
    input  logic            regstat_upd_i,
    input  logic            iq_except_raised_i,   // from fetch
    input  except_code_t    iq_except_code_i,
    input  logic            id_except_raised_i,   // from the decoder
    input  except_code_t    id_except_code_i,
    input  logic            id_stall_possible_i,
    output logic            iq_ready_o,
    output logic            rob_valid_o,
    output logic [EU_N-1:0] ex_valid_o,
    output logic            regstat_valid_o,
    output logic            except_raised_o,
    output except_code_t    except_code_o,
    output logic            main_cu_stall_o
);

    logic unit_ok;   // selected station can take the instr
    logic issue;

    always_comb begin
        unit_ok = (eu_i == EU_NONE);   // ROB only, no station involved
        for (int i = 0; i < EU_N; i++) begin
            if (eu_i == eu_sel_t'(i)) begin
                unit_ok = ex_ready_i[i];
            end
        end
        issue = iq_valid_i && rob_ready_i && regstat_ready_i && unit_ok;

        ex_valid_o = '0;
        for (int i = 0; i < EU_N; i++) begin
            ex_valid_o[i] = issue && (eu_i == eu_sel_t'(i));   // one-hot
        end
    end

    // queue pops exactly when the ROB allocates
    assign iq_ready_o  = issue;
    assign rob_valid_o = issue;

    // rd is marked busy regardless of back-pressure
    assign regstat_valid_o = iq_valid_i && regstat_upd_i;

    // fetch exception is older, so it wins
    always_comb begin
        except_raised_o = iq_except_raised_i || id_except_raised_i;
        except_code_o   = iq_except_code_i;   // don't care when nothing raised
        if (!iq_except_raised_i && id_except_raised_i) begin
            except_code_o = id_except_code_i;
        end
    end

    assign main_cu_stall_o = id_stall_possible_i || except_raised_o;

endmodule

/* hw/issue_logic.sv */
`timescale 1ns/100ps

module issue_logic import issue_pkg::*; #(
    parameter int ROB_IDX_LEN = 4
) (
    // issue queue
    input  logic                   iq_valid_i,
    output logic                   iq_ready_o,
    input  xlen_t                  iq_curr_pc_i,
    input  instr_t                 iq_instruction_i,
    input  logic                   iq_except_raised_i,
    input  except_code_t           iq_except_code_i,
    output logic                   main_cu_stall_o,
    // register status
    input  logic                   regstat_ready_i,
    output logic                   regstat_valid_o,
    input  logic                   regstat_rs1_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i,
    input  logic                   regstat_rs2_busy_i,
    input  logic [ROB_IDX_LEN-1:0] regstat_rs2_rob_idx_i,
    // register file and register status share the source indices
    input  xlen_t                  rf_rs1_value_i,
    input  xlen_t                  rf_rs2_value_i,
    output reg_idx_t               rs1_idx_o,
    output reg_idx_t               rs2_idx_o,
    output reg_idx_t               rd_idx_o,
    // reservation stations
    input  logic [EU_N-1:0]        ex_ready_i,
    output logic [EU_N-1:0]        ex_valid_o,
    output eu_ctl_t                ex_eu_ctl_o,
    output logic                   ex_rs1_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs1_idx_o,   // entry to snoop when not ready
    output xlen_t                  ex_rs1_value_o,
    output logic                   ex_rs2_ready_o,
    output logic [ROB_IDX_LEN-1:0] ex_rs2_idx_o,
    output xlen_t                  ex_rs2_value_o,
    output imm_t                   ex_imm_value_o,
    // CDB
    input  logic                   cdb_valid_i,
    input  logic                   cdb_except_raised_i,
    input  xlen_t                  cdb_value_i,
    input  logic [ROB_IDX_LEN-1:0] cdb_rob_idx_i,
    // ROB
    input  logic                   rob_ready_i,
    output logic                   rob_valid_o,
    input  logic                   rob_rs1_ready_i,
    input  xlen_t                  rob_rs1_value_i,
    input  logic                   rob_rs2_ready_i,
    input  xlen_t                  rob_rs2_value_i,
    output logic                   rob_except_raised_o,
    output except_code_t           rob_except_code_o,
    output xlen_t                  rob_except_aux_o,
    output logic                   rob_res_ready_o
);

    eu_sel_t      id_eu;
    logic         id_rs1_req, id_rs2_req, id_imm_req;
    imm_format_t  id_imm_format;
    logic         id_regstat_upd;
    logic         id_stall_possible;
    logic         id_except_raised;
    except_code_t id_except_code;
    xlen_t        rs1_value, rs2_value;   // fetched operands before routing

    issue_decoder u_issue_decoder (
        .instr_i          (iq_instruction_i),
        .rs1_idx_o        (rs1_idx_o),
        .rs2_idx_o        (rs2_idx_o),
        .rd_idx_o         (rd_idx_o),
        .eu_o             (id_eu),
        .eu_ctl_o         (ex_eu_ctl_o),
        .rs1_req_o        (id_rs1_req),
        .rs2_req_o        (id_rs2_req),
        .imm_req_o        (id_imm_req),
        .imm_format_o     (id_imm_format),
        .regstat_upd_o    (id_regstat_upd),
        .res_ready_o      (rob_res_ready_o),
        .stall_possible_o (id_stall_possible),
        .except_raised_o  (id_except_raised),
        .except_code_o    (id_except_code)
    );

    operand_source_sel #(.ROB_IDX_LEN(ROB_IDX_LEN)) u_rs1_sel (
        .req_i (id_rs1_req), .busy_i (regstat_rs1_busy_i), .rob_idx_i (regstat_rs1_rob_idx_i),
        .rf_value_i (rf_rs1_value_i),
        .rob_ready_i (rob_rs1_ready_i), .rob_value_i (rob_rs1_value_i),
        .cdb_valid_i (cdb_valid_i), .cdb_except_raised_i (cdb_except_raised_i),
        .cdb_rob_idx_i (cdb_rob_idx_i), .cdb_value_i (cdb_value_i),
        .ready_o (ex_rs1_ready_o), .value_o (rs1_value)
    );

    // an immediate also counts as an rs2 request here
    operand_source_sel #(.ROB_IDX_LEN(ROB_IDX_LEN)) u_rs2_sel (
        .req_i (id_rs2_req || id_imm_req), .busy_i (regstat_rs2_busy_i),
        .rob_idx_i (regstat_rs2_rob_idx_i), .rf_value_i (rf_rs2_value_i),
        .rob_ready_i (rob_rs2_ready_i), .rob_value_i (rob_rs2_value_i),
        .cdb_valid_i (cdb_valid_i), .cdb_except_raised_i (cdb_except_raised_i),
        .cdb_rob_idx_i (cdb_rob_idx_i), .cdb_value_i (cdb_value_i),
        .ready_o (ex_rs2_ready_o), .value_o (rs2_value)
    );

    imm_operand_mux u_imm_operand_mux (
        .instr_i        (iq_instruction_i),
        .eu_i           (id_eu),
        .imm_req_i      (id_imm_req),
        .imm_format_i   (id_imm_format),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .ex_rs1_value_o (ex_rs1_value_o),
        .ex_rs2_value_o (ex_rs2_value_o),
        .ex_imm_value_o (ex_imm_value_o)
    );

    issue_control u_issue_control (
        .iq_valid_i          (iq_valid_i),
        .rob_ready_i         (rob_ready_i),
        .regstat_ready_i     (regstat_ready_i),
        .ex_ready_i          (ex_ready_i),
        .eu_i                (id_eu),
        .regstat_upd_i       (id_regstat_upd),
        .iq_except_raised_i  (iq_except_raised_i),
        .iq_except_code_i    (iq_except_code_i),
        .id_except_raised_i  (id_except_raised),
        .id_except_code_i    (id_except_code),
        .id_stall_possible_i (id_stall_possible),
        .iq_ready_o          (iq_ready_o),
        .rob_valid_o         (rob_valid_o),
        .ex_valid_o          (ex_valid_o),
        .regstat_valid_o     (regstat_valid_o),
        .except_raised_o     (rob_except_raised_o),
        .except_code_o       (rob_except_code_o),
        .main_cu_stall_o     (main_cu_stall_o)
    );

    // stations snoop the producer entry given by the register status
    assign ex_rs1_idx_o     = regstat_rs1_rob_idx_i;
    assign ex_rs2_idx_o     = regstat_rs2_rob_idx_i;
    assign rob_except_aux_o = iq_curr_pc_i;   // faulting PC

endmodule

/* bench/issue_model.svh */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// reference decode, taken from the RV64I opcode map
task automatic decode_ref(input instr_t in, output eu_sel_t eu, output logic rs1_req,
                          output logic rs2_req, output logic wr_rd, output logic res_rdy,
                          output logic stall, output logic exc, output except_code_t code);
    eu      = EU_NONE;
    rs1_req = 1'b0;
    rs2_req = 1'b0;             // an immediate counts as an rs2 request
    wr_rd   = 1'b0;
    res_rdy = 1'b0;
    stall   = 1'b1;             // ROB-only instrs stall the main CU
    exc     = 1'b0;
    code    = E_ILLEGAL_INSTR;
    case (in[6:0])
        OPC_LOAD:           eu = EU_LOAD_BUFFER;
        OPC_STORE:          eu = EU_STORE_BUFFER;
        OPC_BRANCH:         eu = EU_BRANCH_UNIT;
        OPC_OP_IMM, OPC_OP: eu = EU_INT_ALU;
        OPC_MISC_MEM:       res_rdy = 1'b1;   // fence
        OPC_SYSTEM: begin
            // only the exact ecall / ebreak words are legal
            res_rdy = (in == 32'h0000_0073) || (in == 32'h0010_0073);
            exc     = 1'b1;
            code    = (in == 32'h0000_0073) ? E_ENV_CALL_M :
                      (in == 32'h0010_0073) ? E_BREAKPOINT : E_ILLEGAL_INSTR;
        end
        default: exc = 1'b1;
    endcase
    if (eu != EU_NONE) begin
        rs1_req = 1'b1;
        rs2_req = (eu != EU_LOAD_BUFFER);
        wr_rd   = (eu == EU_LOAD_BUFFER) || (eu == EU_INT_ALU);
        stall   = 1'b0;
    end
endtask

// funct3 always, alt bit for OP and for OP-IMM right shifts
function automatic eu_ctl_t ctl_ref(input instr_t in);
    eu_ctl_t c;
    c      = '0;
    c[2:0] = in[14:12];
    if (in[6:0] == OPC_OP || (in[6:0] == OPC_OP_IMM && in[14:12] == 3'd5)) c[3] = in[30];
    return c;
endfunction

// returns {ready, value}; RF first, then ROB, then a clean CDB hit
function automatic logic [XLEN:0] operand_ref(input logic req, input logic busy,
        input logic [ROB_IDX_LEN-1:0] idx, input xlen_t rf, input logic rob_rdy,
        input xlen_t rob_val, input logic cv, input logic ce,
        input logic [ROB_IDX_LEN-1:0] cidx, input xlen_t cval);
    if (!req) return '0;
    if (!busy) return {1'b1, rf};
    if (rob_rdy) return {1'b1, rob_val};
    if (cv && !ce && cidx == idx) return {1'b1, cval};
    return '0;   // station must snoop later
endfunction

// raw immediate handed to load, store and branch units
function automatic imm_t imm_ref(input instr_t in, input eu_sel_t eu);
    logic [12:0] b;   // full branch offset, bit 0 implied
    b = {in[31], in[7], in[30:25], in[11:8], 1'b0};
    case (eu)
        EU_LOAD_BUFFER:  return in[31:20];
        EU_STORE_BUFFER: return {in[31:25], in[11:7]};
        EU_BRANCH_UNIT:  return b[12:1];
        default:         return '0;
    endcase
endfunction

// second operand seen by the selected unit
function automatic xlen_t rs2_route_ref(input instr_t in, input eu_sel_t eu, input xlen_t rs2v);
    if (eu == EU_STORE_BUFFER || eu == EU_BRANCH_UNIT) return rs2v;
    if (eu != EU_INT_ALU || in[6:0] == OPC_OP) return (eu == EU_INT_ALU) ? rs2v : '0;
    if (in[14:12] == 3'd1 || in[14:12] == 3'd5) return {58'd0, in[25:20]};   // shamt
    return {{52{in[31]}}, in[31:20]};
endfunction

`endif

/* bench/issue_tb.sv */
`timescale 1ns/100ps

module issue_tb import issue_pkg::*; ();

    localparam int ROB_IDX_LEN = 4;
    localparam int NUM_VEC     = 2000;

    `include "issue_model.svh"

    logic                   clk;
    logic                   arst_n_i = 1'b0;   // gates stimulus only
    logic                   iq_valid_i, iq_except_raised_i, regstat_ready_i, rob_ready_i;
    logic                   regstat_rs1_busy_i, regstat_rs2_busy_i;
    logic                   rob_rs1_ready_i, rob_rs2_ready_i, cdb_valid_i, cdb_except_raised_i;
    xlen_t                  iq_curr_pc_i, rf_rs1_value_i, rf_rs2_value_i, cdb_value_i;
    xlen_t                  rob_rs1_value_i, rob_rs2_value_i;
    instr_t                 iq_instruction_i;
    except_code_t           iq_except_code_i, rob_except_code_o;
    logic [ROB_IDX_LEN-1:0] regstat_rs1_rob_idx_i, regstat_rs2_rob_idx_i, cdb_rob_idx_i;
    logic [EU_N-1:0]        ex_ready_i, ex_valid_o;
    logic                   iq_ready_o, main_cu_stall_o, regstat_valid_o, rob_valid_o;
    logic                   rob_except_raised_o, rob_res_ready_o, ex_rs1_ready_o, ex_rs2_ready_o;
    reg_idx_t               rs1_idx_o, rs2_idx_o, rd_idx_o;
    eu_ctl_t                ex_eu_ctl_o;
    logic [ROB_IDX_LEN-1:0] ex_rs1_idx_o, ex_rs2_idx_o;
    xlen_t                  ex_rs1_value_o, ex_rs2_value_o, rob_except_aux_o;
    imm_t                   ex_imm_value_o;
    int                     errors;

    issue_logic #(.ROB_IDX_LEN(ROB_IDX_LEN)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    initial begin
        repeat (4) @(posedge clk);
        arst_n_i <= 1'b1;
    end

    task automatic check(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // weighted pools per legal class plus raw random words
    function automatic instr_t rand_instr();
        instr_t      w;
        int unsigned pick;
        w    = $urandom;
        pick = $urandom_range(0, 19);
        if (pick < 3) w[6:0] = OPC_LOAD;
        else if (pick < 5) w[6:0] = OPC_STORE;
        else if (pick < 7) w[6:0] = OPC_BRANCH;
        else if (pick < 10) w[6:0] = OPC_OP_IMM;
        else if (pick < 13) w[6:0] = OPC_OP;
        else if (pick == 13) w[6:0] = OPC_MISC_MEM;
        else if (pick == 14) w = 32'h0000_0073;   // ecall
        else if (pick == 15) w = 32'h0010_0073;   // ebreak
        else if (pick == 16) w = {w[31:20], 13'h0, OPC_SYSTEM};   // mostly bad funct12
        return w;
    endfunction

    task automatic drive_inputs();
        iq_valid_i            = arst_n_i && ($urandom_range(0, 9) < 8);
        iq_curr_pc_i          = {$urandom, $urandom};
        iq_instruction_i      = rand_instr();
        iq_except_raised_i    = ($urandom_range(0, 9) == 0);
        iq_except_code_i      = $urandom_range(0, 15);
        regstat_ready_i       = ($urandom_range(0, 3) != 0);
        rob_ready_i           = ($urandom_range(0, 3) != 0);
        ex_ready_i            = $urandom_range(0, 15);
        regstat_rs1_busy_i    = $urandom_range(0, 1);
        regstat_rs2_busy_i    = $urandom_range(0, 1);
        regstat_rs1_rob_idx_i = $urandom_range(0, 3);   // small range for frequent tag hits
        regstat_rs2_rob_idx_i = $urandom_range(0, 3);
        rf_rs1_value_i        = {$urandom, $urandom};
        rf_rs2_value_i        = {$urandom, $urandom};
        rob_rs1_ready_i       = $urandom_range(0, 1);
        rob_rs2_ready_i       = $urandom_range(0, 1);
        rob_rs1_value_i       = {$urandom, $urandom};
        rob_rs2_value_i       = {$urandom, $urandom};
        cdb_valid_i           = ($urandom_range(0, 3) != 0);
        cdb_except_raised_i   = ($urandom_range(0, 4) == 0);
        cdb_rob_idx_i         = $urandom_range(0, 3);
        cdb_value_i           = {$urandom, $urandom};
    endtask

    task automatic check_outputs();
        eu_sel_t         eu;
        logic            rs1_req, rs2_req, wr_rd, res_rdy, stall, id_exc, issue;
        except_code_t    id_code, exp_code;
        logic [EU_N-1:0] exp_valid;
        logic [XLEN:0]   op1, op2;   // {ready, value}
        decode_ref(iq_instruction_i, eu, rs1_req, rs2_req, wr_rd, res_rdy, stall, id_exc, id_code);
        issue = iq_valid_i && rob_ready_i && regstat_ready_i
                && ((eu == EU_NONE) || ex_ready_i[eu[1:0]]);
        exp_valid = '0;
        if (issue && eu != EU_NONE) exp_valid[eu[1:0]] = 1'b1;
        op1 = operand_ref(rs1_req, regstat_rs1_busy_i, regstat_rs1_rob_idx_i, rf_rs1_value_i,
                          rob_rs1_ready_i, rob_rs1_value_i, cdb_valid_i, cdb_except_raised_i,
                          cdb_rob_idx_i, cdb_value_i);
        op2 = operand_ref(rs2_req, regstat_rs2_busy_i, regstat_rs2_rob_idx_i, rf_rs2_value_i,
                          rob_rs2_ready_i, rob_rs2_value_i, cdb_valid_i, cdb_except_raised_i,
                          cdb_rob_idx_i, cdb_value_i);
        exp_code = iq_except_raised_i ? iq_except_code_i : (id_exc ? id_code : iq_except_code_i);
        check("rs1_idx", iq_instruction_i[19:15], rs1_idx_o);
        check("rs2_idx", iq_instruction_i[24:20], rs2_idx_o);
        check("rd_idx", iq_instruction_i[11:7], rd_idx_o);
        check("eu_ctl", ctl_ref(iq_instruction_i), ex_eu_ctl_o);
        check("iq_ready", issue, iq_ready_o);
        check("rob_valid", issue, rob_valid_o);
        check("iq_ready_vs_rob_valid", rob_valid_o, iq_ready_o);
        check("ex_valid", exp_valid, ex_valid_o);
        check("regstat_valid", iq_valid_i && wr_rd, regstat_valid_o);
        check("rs1_ready", op1[XLEN], ex_rs1_ready_o);
        check("rs2_ready", op2[XLEN], ex_rs2_ready_o);
        check("rs1_value", (eu == EU_NONE) ? '0 : op1[XLEN-1:0], ex_rs1_value_o);
        check("rs2_value", rs2_route_ref(iq_instruction_i, eu, op2[XLEN-1:0]), ex_rs2_value_o);
        check("imm_value", imm_ref(iq_instruction_i, eu), ex_imm_value_o);
        check("rs1_rob_idx", regstat_rs1_rob_idx_i, ex_rs1_idx_o);
        check("rs2_rob_idx", regstat_rs2_rob_idx_i, ex_rs2_idx_o);
        check("except_raised", iq_except_raised_i || id_exc, rob_except_raised_o);
        check("except_code", exp_code, rob_except_code_o);
        check("except_aux", iq_curr_pc_i, rob_except_aux_o);
        check("cu_stall", stall || iq_except_raised_i || id_exc, main_cu_stall_o);
        check("res_ready", res_rdy, rob_res_ready_o);
    endtask

    initial begin
        int wait_cnt;
        void'($urandom(93287));       // one seed for the whole run
        errors   = 0;
        drive_inputs();               // every input defined from time 0
        wait_cnt = 0;
        while (!arst_n_i && wait_cnt < 20) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!arst_n_i) begin
            $display("reset was not released within %0d cycles", wait_cnt);
            $display("Done: errors found");
            $finish;
        end
        for (int n = 0; n < NUM_VEC; n++) begin
            @(negedge clk);
            drive_inputs();
            @(posedge clk);           // comb outputs settled half a cycle ago
            check_outputs();
        end
        $display("vectors: %0d  errors: %0d", NUM_VEC, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* issue_logic.f */
+incdir+bench
hw/issue_pkg.sv
hw/issue_decoder.sv
hw/operand_source_sel.sv
hw/imm_operand_mux.sv
hw/issue_control.sv
hw/issue_logic.sv
bench/issue_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the issue stage testbench with Verilator, run it, then look for the pass line
rm -f sim.log && rm -rf obj_dir \
    && verilator --binary --timing -Wno-fatal --top-module issue_tb -f issue_logic.f -o issue_sim \
    && ./obj_dir/issue_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Done: no errors" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
